// ==== src/isa_pkg.sv ====
package isa_pkg;

    // Architectural word and register index
    typedef logic [15:0] word_t;
    typedef logic [3:0]  reg_idx_t;

    localparam int       NUM_REGS    = 16;
    localparam reg_idx_t DISPLAY_REG = 4'd3; // r3 drives the display

    // Top two instruction bits
    typedef enum logic [1:0] {
        OP_R = 2'b00, // Register and ALU
        OP_M = 2'b01, // Memory, stack only
        OP_J = 2'b10, // Jumps, not decoded
        OP_X = 2'b11  // Extended, not decoded
    } op_family_t;

    // Mod field, R family
    typedef enum logic [5:0] {
        F_MOV  = 6'b000000,
        F_ADD  = 6'b000001,
        F_XOR  = 6'b000101,
        F_ADDI = 6'b010000  // Immediate sits in Src
    } r_func_t;

    // Mod field, M family
    typedef enum logic [5:0] {
        F_PUSH = 6'b000010,
        F_POP  = 6'b000011
    } m_func_t;

    // Instruction layout [Op:2][Mod:6][Src:4][Dst:4]
    typedef struct packed {
        op_family_t op;
        logic [5:0] mod;
        reg_idx_t   src;
        reg_idx_t   dst;
    } instr_t;

    typedef enum logic [2:0] {
        S_INIT_WR, S_INIT_WR_WAIT, S_INIT_RD, S_INIT_RD_WAIT,
        S_FETCH, S_PUSH_WAIT, S_POP_WAIT
    } exec_state_t;

endpackage

// ==== src/board_pkg.sv ====
package board_pkg;

    // Single clock domain
    localparam int CLK_FREQ_HZ    = 100_000_000;
    localparam int BAUD_RATE      = 115200;
    localparam int CYCLES_PER_BIT = CLK_FREQ_HZ / BAUD_RATE; // 868 at 100 MHz

    // Byte addressed external memory
    localparam int ADDR_W = 24;
    typedef logic [ADDR_W-1:0] addr_t;

    // Power-up fill of the stack area
    localparam addr_t       INIT_BASE    = 24'h900000;
    localparam int          INIT_WORDS   = 32;
    localparam logic [15:0] INIT_PATTERN = 16'hA301;

    // Stack grows upward, one 16-bit word per slot
    localparam addr_t SP_RESET = 24'h900010;
    localparam addr_t SP_STEP  = 24'd2;

    // Display
    localparam int NUM_DIGITS  = 6;
    localparam int HEX_DIGITS  = 4;
    localparam int SCAN_CYCLES = 1000; // Dwell per digit, 10 us

    typedef logic [7:0] seg_t; // {dp,g,f,e,d,c,b,a}, low = lit
    localparam seg_t SEG_BLANK = 8'hFF;

endpackage

// ==== src/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx import board_pkg::*; (
    input  logic       clk_100mhz,
    input  logic       rst_n,
    input  logic       rx_pin,
    output logic [7:0] rx_data,
    output logic       rx_data_valid,
    input  logic       rx_data_ready
);

    typedef enum logic [1:0] {
        RX_IDLE, RX_START, RX_DATA, RX_STOP
    } rx_state_t;

    rx_state_t                           state;
    logic [2:0]                          sync;    // Two flops plus edge history
    logic [$clog2(CYCLES_PER_BIT)-1:0]   cnt;     // Clocks within a bit
    logic [2:0]                          bit_idx;
    logic [7:0]                          shift;
    logic                                rx_s;
    logic                                fall;
    logic                                byte_done;

    assign rx_s = sync[1];
    assign fall = sync[2] && !sync[1]; // Start bit edge

    // Metastability guard
    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) sync <= 3'b111; // Idle line is high
        else        sync <= {sync[1:0], rx_pin};
    end

    // Bit timing, all sampling at mid-bit
    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
        end else begin
            cnt <= cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (fall) state <= RX_START;
                end
                RX_START: if (cnt == CYCLES_PER_BIT / 2 - 1) begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    state   <= rx_s ? RX_IDLE : RX_DATA; // Glitch rejected
                end
                RX_DATA: if (cnt == CYCLES_PER_BIT - 1) begin
                    cnt     <= '0;
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) state <= RX_STOP;
                end
                RX_STOP: if (cnt == CYCLES_PER_BIT - 1) state <= RX_IDLE;
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB first
    always_ff @(posedge clk_100mhz) begin
        if (state == RX_DATA && cnt == CYCLES_PER_BIT - 1) shift <= {rx_s, shift[7:1]};
    end

    assign byte_done = (state == RX_STOP) && (cnt == CYCLES_PER_BIT - 1);

    // Held until taken; a newer byte replaces it
    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            rx_data       <= '0;
            rx_data_valid <= 1'b0;
        end else if (byte_done) begin
            rx_data       <= shift;
            rx_data_valid <= 1'b1;
        end else if (rx_data_valid && rx_data_ready) begin
            rx_data_valid <= 1'b0;
        end
    end

endmodule

// ==== src/hex_digit_decoder.sv ====
`timescale 1ns/1ps

module hex_digit_decoder import board_pkg::*; (
    input  logic [3:0] nibble,
    output seg_t       seg
);

    // Common anode, dp off in every entry
    always_comb begin
        case (nibble)
            4'h0: seg = 8'hC0;
            4'h1: seg = 8'hF9;
            4'h2: seg = 8'hA4;
            4'h3: seg = 8'hB0;
            4'h4: seg = 8'h99;
            4'h5: seg = 8'h92;
            4'h6: seg = 8'h82;
            4'h7: seg = 8'hF8;
            4'h8: seg = 8'h80;
            4'h9: seg = 8'h90;
            4'hA: seg = 8'h88;
            4'hB: seg = 8'h83; // Lower case b
            4'hC: seg = 8'hC6;
            4'hD: seg = 8'hA1; // Lower case d
            4'hE: seg = 8'h86;
            4'hF: seg = 8'h8E;
            default: seg = SEG_BLANK;
        endcase
    end

endmodule

// ==== src/seg_scan.sv ====
`timescale 1ns/1ps

module seg_scan import board_pkg::*; (
    input  logic                  clk_100mhz,
    input  logic                  rst_n,
    input  seg_t                  digit_seg [HEX_DIGITS],
    output logic [NUM_DIGITS-1:0] seg_sel,
    output seg_t                  seg_data
);

    logic [$clog2(SCAN_CYCLES)-1:0] dwell;
    logic [2:0]                     idx;   // Digit being driven
    seg_t                           pattern;

    // Upper digits have no source
    assign pattern = (idx < HEX_DIGITS) ? digit_seg[idx[1:0]] : SEG_BLANK;

    // Dwell counter and digit rotation
    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            dwell <= '0;
            idx   <= '0;
        end else if (dwell == SCAN_CYCLES - 1) begin
            dwell <= '0;
            idx   <= (idx == NUM_DIGITS - 1) ? 3'd0 : idx + 1'b1;
        end else begin
            dwell <= dwell + 1'b1;
        end
    end

    // Select and pattern registered together so they switch in step
    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            seg_sel  <= ~NUM_DIGITS'(1); // Digit 0 first
            seg_data <= SEG_BLANK;
        end else begin
            seg_sel  <= ~(NUM_DIGITS'(1) << idx);
            seg_data <= pattern;
        end
    end

    // Never two digits lit, never none
    a_sel_onehot: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        $onehot(~seg_sel));

endmodule

// ==== src/stack_cpu.sv ====
`timescale 1ns/1ps

module stack_cpu import isa_pkg::*, board_pkg::*; (
    input  logic       clk_100mhz,
    input  logic       rst_n,
    input  logic [7:0] rx_data,
    input  logic       rx_data_valid,
    output logic       rx_data_ready,
    output logic       wr_burst_req,
    output addr_t      wr_burst_addr,
    output word_t      wr_burst_data,
    input  logic       wr_burst_data_req,
    input  logic       wr_burst_finish,
    output logic       rd_burst_req,
    output addr_t      rd_burst_addr,
    input  word_t      rd_burst_data,
    input  logic       rd_burst_data_valid,
    input  logic       rd_burst_finish,
    output word_t      display_value
);

    exec_state_t                      state;
    word_t                            regs [NUM_REGS];
    addr_t                            sp;
    logic [$clog2(INIT_WORDS+1)-1:0]  init_cnt;
    logic [7:0]                       byte_hi;  // High byte arrives first
    logic                             have_hi;
    word_t                            wr_hold;  // Staged until memory asks
    reg_idx_t                         rd_dst;   // Target of a pending read
    instr_t                           ins;
    logic                             take;
    logic                             second;
    logic                             is_push;
    logic                             is_pop;

    assign rx_data_ready = (state == S_FETCH); // Low during init and bursts
    assign take          = rx_data_valid && rx_data_ready;
    assign second        = take && have_hi;
    assign ins           = {byte_hi, rx_data};
    assign display_value = regs[DISPLAY_REG];

    // Stack ops only on a complete pair
    always_comb begin
        is_push = 1'b0;
        is_pop  = 1'b0;
        if (second && ins.op == OP_M) begin
            case (m_func_t'(ins.mod))
                F_PUSH:  is_push = 1'b1;
                F_POP:   is_pop  = 1'b1;
                default: ; // Unknown Mod ignored
            endcase
        end
    end

    // Control path
    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_INIT_WR;
            sp           <= SP_RESET;
            init_cnt     <= '0;
            have_hi      <= 1'b0;
            wr_burst_req <= 1'b0;
            rd_burst_req <= 1'b0;
        end else begin
            case (state)
                S_INIT_WR: begin
                    if (init_cnt == INIT_WORDS) begin
                        state <= S_INIT_RD;
                    end else begin
                        wr_burst_req <= 1'b1;
                        state        <= S_INIT_WR_WAIT;
                    end
                end
                S_INIT_WR_WAIT: if (wr_burst_finish) begin
                    wr_burst_req <= 1'b0;
                    init_cnt     <= init_cnt + 1'b1;
                    state        <= S_INIT_WR;
                end
                S_INIT_RD: begin
                    rd_burst_req <= 1'b1;
                    state        <= S_INIT_RD_WAIT;
                end
                S_FETCH: begin
                    if (take) have_hi <= !have_hi;
                    if (is_push) begin
                        wr_burst_req <= 1'b1;
                        sp           <= sp + SP_STEP;
                        state        <= S_PUSH_WAIT;
                    end else if (is_pop) begin
                        rd_burst_req <= 1'b1;
                        sp           <= sp - SP_STEP;
                        state        <= S_POP_WAIT;
                    end
                end
                S_PUSH_WAIT: if (wr_burst_finish) begin
                    wr_burst_req <= 1'b0;
                    state        <= S_FETCH;
                end
                S_INIT_RD_WAIT, S_POP_WAIT: if (rd_burst_finish) begin
                    rd_burst_req <= 1'b0;
                    state        <= S_FETCH;
                end
                default: state <= S_FETCH;
            endcase
        end
    end

    // Burst payload and instruction byte
    always_ff @(posedge clk_100mhz) begin
        if (take && !have_hi) byte_hi <= rx_data;
        if (state == S_INIT_WR) begin
            wr_burst_addr <= INIT_BASE + addr_t'({init_cnt, 1'b0}); // Word stride
            wr_hold       <= INIT_PATTERN;
        end
        if (state == S_INIT_RD) begin
            rd_burst_addr <= INIT_BASE;
            rd_dst        <= DISPLAY_REG;
        end
        if (is_push) begin
            wr_burst_addr <= sp;
            wr_hold       <= regs[ins.dst];
        end
        if (is_pop) begin
            rd_burst_addr <= sp - SP_STEP; // Slot below the top
            rd_dst        <= ins.dst;
        end
        if (wr_burst_data_req) wr_burst_data <= wr_hold;
    end

    // Register file, ALU and read return
    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) regs[i] <= '0;
        end else if (rd_burst_req && rd_burst_data_valid) begin
            regs[rd_dst] <= rd_burst_data;
        end else if (second && ins.op == OP_R) begin
            case (r_func_t'(ins.mod))
                F_MOV:   regs[ins.dst] <= regs[ins.src];
                F_ADD:   regs[ins.dst] <= regs[ins.dst] + regs[ins.src];
                F_XOR:   regs[ins.dst] <= regs[ins.dst] ^ regs[ins.src];
                F_ADDI:  regs[ins.dst] <= regs[ins.dst] + word_t'(ins.src);
                default: ;
            endcase
        end
    end

    // Memory side sees one burst at a time
    a_one_req: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        !(wr_burst_req && rd_burst_req));

    // Requests only drop after the controller has finished
    a_wr_hold: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        $fell(wr_burst_req) |-> $past(wr_burst_finish));
    a_rd_hold: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
        $fell(rd_burst_req) |-> $past(rd_burst_finish));

endmodule

// ==== src/uart_hex_cpu.sv ====
`timescale 1ns/1ps

module uart_hex_cpu import isa_pkg::*, board_pkg::*; (
    input  logic                  clk_100mhz,
    input  logic                  rst_n,
    input  logic                  uart_rx,
    output logic [NUM_DIGITS-1:0] seg_sel,
    output seg_t                  seg_data,
    output logic                  wr_burst_req,
    output addr_t                 wr_burst_addr,
    output word_t                 wr_burst_data,
    input  logic                  wr_burst_data_req,
    input  logic                  wr_burst_finish,
    output logic                  rd_burst_req,
    output addr_t                 rd_burst_addr,
    input  word_t                 rd_burst_data,
    input  logic                  rd_burst_data_valid,
    input  logic                  rd_burst_finish
);

    logic [7:0] rx_data;
    logic       rx_data_valid;
    logic       rx_data_ready;
    word_t      display_value; // r3
    seg_t       digit_seg [HEX_DIGITS];

    uart_rx u_uart_rx (
        .clk_100mhz, .rst_n, .rx_pin(uart_rx),
        .rx_data, .rx_data_valid, .rx_data_ready
    );

    stack_cpu u_stack_cpu (
        .clk_100mhz, .rst_n,
        .rx_data, .rx_data_valid, .rx_data_ready,
        .wr_burst_req, .wr_burst_addr, .wr_burst_data,
        .wr_burst_data_req, .wr_burst_finish,
        .rd_burst_req, .rd_burst_addr, .rd_burst_data,
        .rd_burst_data_valid, .rd_burst_finish,
        .display_value
    );

    // Leftmost digit gets the top nibble
    for (genvar k = 0; k < HEX_DIGITS; k++) begin : g_dec
        hex_digit_decoder u_dec (
            .nibble(display_value[4*(HEX_DIGITS-1-k) +: 4]),
            .seg   (digit_seg[k])
        );
    end

    seg_scan u_seg_scan (.clk_100mhz, .rst_n, .digit_seg, .seg_sel, .seg_data);

endmodule

// ==== tb/display_checker.sv ====
`timescale 1ns/1ps

module display_checker import isa_pkg::*, board_pkg::*; (
    input  logic                  clk_100mhz,
    input  logic                  rst_n,
    input  logic [NUM_DIGITS-1:0] seg_sel,
    input  seg_t                  seg_data,
    input  addr_t                 wr_burst_addr,
    input  word_t                 wr_burst_data,
    input  logic                  wr_burst_finish,
    input  logic                  rd_burst_req,
    input  addr_t                 rd_burst_addr,
    input  logic                  rd_burst_data_valid,
    input  logic                  exp_strobe,
    input  logic                  exp_init,
    input  word_t                 exp_r3,
    input  logic                  exp_wr,
    input  addr_t                 exp_wr_addr,
    input  word_t                 exp_wr_data,
    input  logic                  exp_rd,
    input  addr_t                 exp_rd_addr,
    output logic                  check_done,
    output int                    mismatch_count,
    output int                    timeout_count
);

    localparam int BURST_TIMEOUT = 2000;                        // Cycles per burst wait
    localparam int SCAN_WINDOW   = NUM_DIGITS * SCAN_CYCLES + 20; // One full refresh

    addr_t wr_addr_q [$];
    word_t wr_data_q [$];
    addr_t rd_addr_q [$];
    seg_t  shown [NUM_DIGITS]; // Last pattern seen per digit

    // Own copy of the common-anode table, {valid, nibble}
    function automatic logic [4:0] seg_to_nibble(input seg_t s);
        case (s)
            8'hC0: return 5'h10;
            8'hF9: return 5'h11;
            8'hA4: return 5'h12;
            8'hB0: return 5'h13;
            8'h99: return 5'h14;
            8'h92: return 5'h15;
            8'h82: return 5'h16;
            8'hF8: return 5'h17;
            8'h80: return 5'h18;
            8'h90: return 5'h19;
            8'h88: return 5'h1A;
            8'h83: return 5'h1B;
            8'hC6: return 5'h1C;
            8'hA1: return 5'h1D;
            8'h86: return 5'h1E;
            8'h8E: return 5'h1F;
            default: return 5'h00; // Not a hex glyph
        endcase
    endfunction

    // Bus log and display capture, sampled mid-cycle
    always @(negedge clk_100mhz) begin : log_bus
        if (rst_n) begin
            if (wr_burst_finish) begin
                wr_addr_q.push_back(wr_burst_addr);
                wr_data_q.push_back(wr_burst_data);
            end
            if (rd_burst_req && rd_burst_data_valid) rd_addr_q.push_back(rd_burst_addr);
            for (int i = 0; i < NUM_DIGITS; i++) begin
                if (!seg_sel[i]) shown[i] = seg_data; // Active-low select
            end
        end
    end

    task automatic take_write(input addr_t ea, input word_t ed);
        int    n;
        addr_t a;
        word_t d;
        n = 0;
        while (wr_addr_q.size() == 0 && n < BURST_TIMEOUT) begin
            @(negedge clk_100mhz);
            n++;
        end
        if (wr_addr_q.size() == 0) begin
            $display("Timeout at %0t: no write burst seen for address %h", $time, ea);
            timeout_count++;
        end else begin
            a = wr_addr_q.pop_front();
            d = wr_data_q.pop_front();
            if (a !== ea || d !== ed) begin
                $display("Mismatch at %0t: write %h=%h, expected %h=%h", $time, a, d, ea, ed);
                mismatch_count++;
            end
        end
    endtask

    task automatic take_read(input addr_t ea);
        int    n;
        addr_t a;
        n = 0;
        while (rd_addr_q.size() == 0 && n < BURST_TIMEOUT) begin
            @(negedge clk_100mhz);
            n++;
        end
        if (rd_addr_q.size() == 0) begin
            $display("Timeout at %0t: no read burst seen for address %h", $time, ea);
            timeout_count++;
        end else begin
            a = rd_addr_q.pop_front();
            if (a !== ea) begin
                $display("Mismatch at %0t: read at %h, expected %h", $time, a, ea);
                mismatch_count++;
            end
        end
    endtask

    // Rebuild the shown value after one whole refresh
    task automatic check_display(input word_t ev);
        word_t      v;
        logic [4:0] r;
        logic       bad;
        v   = '0;
        bad = 1'b0;
        repeat (SCAN_WINDOW) @(negedge clk_100mhz);
        for (int i = 0; i < HEX_DIGITS; i++) begin
            r = seg_to_nibble(shown[i]);
            if (!r[4]) bad = 1'b1;
            v = {v[11:0], r[3:0]}; // Digit 0 is the top nibble
        end
        if (bad || v !== ev) begin
            $display("Mismatch at %0t: display shows %h, expected %h", $time, v, ev);
            mismatch_count++;
        end
        for (int i = HEX_DIGITS; i < NUM_DIGITS; i++) begin
            if (shown[i] !== SEG_BLANK) begin
                $display("Mismatch at %0t: digit %0d not blank (%h)", $time, i, shown[i]);
                mismatch_count++;
            end
        end
    endtask

    task automatic run_check();
        if (exp_init) begin
            for (int k = 0; k < INIT_WORDS; k++) take_write(INIT_BASE + addr_t'(2 * k), INIT_PATTERN);
            take_read(INIT_BASE);
        end else begin
            if (exp_wr) take_write(exp_wr_addr, exp_wr_data);
            if (exp_rd) take_read(exp_rd_addr);
            if (!exp_wr && !exp_rd && (wr_addr_q.size() != 0 || rd_addr_q.size() != 0)) begin
                $display("Mismatch at %0t: burst seen where none was expected", $time);
                mismatch_count++;
                wr_addr_q.delete();
                wr_data_q.delete();
                rd_addr_q.delete();
            end
        end
        check_display(exp_r3);
    endtask

    initial begin
        check_done     = 1'b0;
        mismatch_count = 0;
        timeout_count  = 0;
        forever begin
            @(negedge clk_100mhz);
            if (exp_strobe) begin
                check_done = 1'b0;
                run_check();
                check_done = 1'b1; // Top may send the next instruction
            end
        end
    end

endmodule

// ==== tb/tb_uart_hex_cpu.sv ====
`timescale 1ns/1ps

module tb_uart_hex_cpu import isa_pkg::*, board_pkg::*; ();

    localparam int CHECK_TIMEOUT = 40000; // Cycles for one checker pass

    logic                  clk_100mhz;
    logic                  rst_n;
    logic                  uart_line;
    logic [NUM_DIGITS-1:0] seg_sel;
    seg_t                  seg_data;
    logic                  wr_burst_req, wr_burst_data_req, wr_burst_finish;
    addr_t                 wr_burst_addr, rd_burst_addr;
    word_t                 wr_burst_data, rd_burst_data;
    logic                  rd_burst_req, rd_burst_data_valid, rd_burst_finish;

    logic  exp_strobe, exp_init, exp_wr, exp_rd, check_done;
    word_t exp_r3, exp_wr_data;
    addr_t exp_wr_addr, exp_rd_addr;
    int    mismatch_count, timeout_count;
    int    tb_timeouts;
    logic  aborted;
    int    seed_val;

    word_t mem [addr_t];     // Bus side memory
    word_t ref_mem [addr_t]; // Reference view of the same memory
    word_t ref_regs [NUM_REGS];
    addr_t ref_sp;

    uart_hex_cpu u_uart_hex_cpu (
        .clk_100mhz, .rst_n, .uart_rx(uart_line), .seg_sel, .seg_data,
        .wr_burst_req, .wr_burst_addr, .wr_burst_data, .wr_burst_data_req, .wr_burst_finish,
        .rd_burst_req, .rd_burst_addr, .rd_burst_data, .rd_burst_data_valid, .rd_burst_finish
    );

    display_checker u_display_checker (
        .clk_100mhz, .rst_n, .seg_sel, .seg_data,
        .wr_burst_addr, .wr_burst_data, .wr_burst_finish,
        .rd_burst_req, .rd_burst_addr, .rd_burst_data_valid,
        .exp_strobe, .exp_init, .exp_r3, .exp_wr, .exp_wr_addr, .exp_wr_data,
        .exp_rd, .exp_rd_addr, .check_done, .mismatch_count, .timeout_count
    );

    initial begin
        clk_100mhz = 1'b0;
        forever #5 clk_100mhz = ~clk_100mhz;
    end

    // Unwritten locations, every address bit matters
    function automatic word_t fill_word(input addr_t a);
        return a[15:0] ^ {a[23:16], a[23:16]} ^ 16'h5A5A;
    endfunction

    function automatic word_t ref_load(input addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
    endfunction

    // One instruction on the model state, plus the burst it should cause
    function automatic void ref_step(input word_t ins, output logic wr, output addr_t wa,
                                     output word_t wd, output logic rd, output addr_t ra);
        logic [1:0] op;
        logic [5:0] mod;
        reg_idx_t   s, d;
        op  = ins[15:14];
        mod = ins[13:8];
        s   = ins[7:4];
        d   = ins[3:0];
        wr  = 1'b0;
        rd  = 1'b0;
        wa  = '0;
        wd  = '0;
        ra  = '0;
        if (op == OP_R) begin
            if (mod == F_MOV)       ref_regs[d] = ref_regs[s];
            else if (mod == F_ADD)  ref_regs[d] = ref_regs[d] + ref_regs[s];
            else if (mod == F_XOR)  ref_regs[d] = ref_regs[d] ^ ref_regs[s];
            else if (mod == F_ADDI) ref_regs[d] = ref_regs[d] + {12'h000, s};
        end else if (op == OP_M) begin
            if (mod == F_PUSH) begin
                wr          = 1'b1;
                wa          = ref_sp;
                wd          = ref_regs[d];
                ref_mem[wa] = wd;
                ref_sp      = ref_sp + 24'd2;
            end else if (mod == F_POP) begin
                rd          = 1'b1;
                ra          = ref_sp - 24'd2; // Slot just below sp
                ref_regs[d] = ref_load(ra);
                ref_sp      = ref_sp - 24'd2;
            end
        end
    endfunction

    // Burst memory with random latency
    initial begin
        wr_burst_data_req   = 1'b0;
        wr_burst_finish     = 1'b0;
        rd_burst_data       = '0;
        rd_burst_data_valid = 1'b0;
        rd_burst_finish     = 1'b0;
        forever begin
            @(posedge clk_100mhz);
            #1;
            if (wr_burst_req) serve_write();
            else if (rd_burst_req) serve_read();
        end
    end

    task automatic serve_write();
        addr_t a;
        word_t d;
        a = wr_burst_addr;
        repeat ($urandom_range(1, 8)) @(posedge clk_100mhz);
        #1 wr_burst_data_req = 1'b1;
        @(posedge clk_100mhz);
        #1 wr_burst_data_req = 1'b0;
        @(posedge clk_100mhz);
        #1 d = wr_burst_data; // Registered by the CPU one cycle back
        @(posedge clk_100mhz);
        #1 wr_burst_finish = 1'b1;
        @(posedge clk_100mhz);
        #1 wr_burst_finish = 1'b0;
        mem[a] = d;
    endtask

    task automatic serve_read();
        addr_t a;
        a = rd_burst_addr;
        repeat ($urandom_range(1, 8)) @(posedge clk_100mhz);
        #1;
        rd_burst_data       = mem.exists(a) ? mem[a] : fill_word(a);
        rd_burst_data_valid = 1'b1;
        rd_burst_finish     = 1'b1; // Single word, finish with the data
        @(posedge clk_100mhz);
        #1;
        rd_burst_data_valid = 1'b0;
        rd_burst_finish     = 1'b0;
    endtask

    // 8N1, LSB first
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        @(posedge clk_100mhz);
        #1;
        for (int i = 0; i < 10; i++) begin
            uart_line = frame[i];
            repeat (CYCLES_PER_BIT) @(posedge clk_100mhz);
            #1;
        end
    endtask

    task automatic hand_over_and_wait();
        int n;
        exp_strobe = 1'b1;
        @(posedge clk_100mhz);
        #1 exp_strobe = 1'b0;
        n = 0;
        while (!check_done && n < CHECK_TIMEOUT) begin
            @(posedge clk_100mhz);
            #1;
            n++;
        end
        if (!check_done) begin
            $display("Timeout at %0t: checker did not finish its comparison", $time);
            tb_timeouts++;
            aborted = 1'b1;
        end
    endtask

    task automatic run_instr(input word_t ins);
        if (!aborted) begin
            ref_step(ins, exp_wr, exp_wr_addr, exp_wr_data, exp_rd, exp_rd_addr);
            exp_r3   = ref_regs[DISPLAY_REG];
            exp_init = 1'b0;
            send_byte(ins[15:8]); // High byte first
            send_byte(ins[7:0]);
            hand_over_and_wait();
        end
    endtask

    task automatic end_run();
        $display("Errors: %0d mismatches, %0d checker timeouts, %0d testbench timeouts",
                 mismatch_count, timeout_count, tb_timeouts);
        if (mismatch_count + timeout_count + tb_timeouts == 0) $display(">>> PASS");
        else $display(">>> FAIL");
        $finish;
    endtask

    initial begin
        r_func_t f;
        reg_idx_t src, dst;
        seed_val    = $urandom(90);
        rst_n       = 1'b0;
        uart_line   = 1'b1; // Idle line
        exp_strobe  = 1'b0;
        exp_init    = 1'b0;
        exp_wr      = 1'b0;
        exp_rd      = 1'b0;
        exp_r3      = '0;
        exp_wr_addr = '0;
        exp_wr_data = '0;
        exp_rd_addr = '0;
        tb_timeouts = 0;
        aborted     = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) ref_regs[i] = '0;
        ref_sp = SP_RESET;
        repeat (5) @(posedge clk_100mhz);
        #1 rst_n = 1'b1;

        // Power-up fill and r3 readback
        for (int k = 0; k < INIT_WORDS; k++) ref_mem[INIT_BASE + addr_t'(2 * k)] = INIT_PATTERN;
        ref_regs[DISPLAY_REG] = ref_load(INIT_BASE);
        exp_r3   = ref_regs[DISPLAY_REG];
        exp_init = 1'b1;
        hand_over_and_wait();

        // r3 moved off A301 so the POP has something to restore
        run_instr({OP_R, F_ADDI, 4'h1, 4'h3});

        // POP before any PUSH, then ignored encodings
        run_instr({OP_M, F_POP, 4'h0, 4'h3});
        run_instr({OP_R, 6'b111111, 4'h1, 4'h3});
        run_instr({OP_M, 6'b000111, 4'h0, 4'h3});
        run_instr({OP_J, F_ADD, 4'h3, 4'h3}); // Would double r3 if decoded
        run_instr({OP_X, F_ADDI, 4'h7, 4'h3});

        // Random ALU series, mostly into r3
        for (int i = 0; i < 12; i++) begin
            case ($urandom_range(0, 3))
                0:       f = F_MOV;
                1:       f = F_ADD;
                2:       f = F_XOR;
                default: f = F_ADDI;
            endcase
            src = reg_idx_t'($urandom_range(0, 15));
            dst = (i % 3 == 2) ? reg_idx_t'($urandom_range(0, 15)) : DISPLAY_REG;
            run_instr({OP_R, f, src, dst});
        end

        // Stack round trip
        run_instr({OP_R, F_ADDI, 4'h9, 4'h5});
        run_instr({OP_M, F_PUSH, 4'h0, 4'h3});
        run_instr({OP_M, F_PUSH, 4'h0, 4'h5});
        run_instr({OP_M, F_POP, 4'h0, 4'h3});
        run_instr({OP_M, F_POP, 4'h0, 4'h3});
        end_run();
    end

endmodule

// ==== uart_hex_cpu.f ====
src/isa_pkg.sv
src/board_pkg.sv
src/uart_rx.sv
src/hex_digit_decoder.sv
src/seg_scan.sv
src/stack_cpu.sv
src/uart_hex_cpu.sv
tb/display_checker.sv
tb/tb_uart_hex_cpu.sv
